/* logic/cmd_pkg.sv */
package cmd_pkg;

	// ====================
	// Command word widths
	// ====================

	// One FIFO word
	localparam int CMD_W = 32;
	// Opcode field
	localparam int OPC_W = 4;
	// Each of the x and y arguments
	localparam int ARG_W = 14;

	// ====================
	// Opcodes
	// ====================

	// Counted only
	localparam logic [OPC_W-1:0] OPC_NOP       = 4'd0;
	// One LED, index in x, level in y bit 0
	localparam logic [OPC_W-1:0] OPC_LED_SET   = 4'd1;
	// Binary count on the LEDs
	localparam logic [OPC_W-1:0] OPC_RUN_START = 4'd2;
	localparam logic [OPC_W-1:0] OPC_RUN_STOP  = 4'd3;
	// One-shot inversion of all LEDs
	localparam logic [OPC_W-1:0] OPC_INVERT    = 4'd4;

	// Field view, LSB first in the word
	typedef struct packed {
		logic [ARG_W-1:0] y_value;
		logic [ARG_W-1:0] x_value;
		logic [OPC_W-1:0] opcode;
	} cmd_fields_t;

	// Raw view for the FIFO side, field view for the decoder
	typedef union packed {
		logic [CMD_W-1:0] raw;
		cmd_fields_t      f;
	} cmd_word_u;

endpackage

/* logic/board_pkg.sv */
package board_pkg;

	// ====================
	// Board outputs
	// ====================

	// Red LEDs LEDR[9:0]
	localparam int LED_N = 10;

	// Seven-segment digits in use, HEX0 to HEX3
	localparam int HEX_DIGITS = 4;
	// Segments per digit, a to g
	localparam int SEG_W = 7;

	// Command counter, one hex nibble per digit
	localparam int CNT_W = 16;

	// ====================
	// Timing
	// ====================

	// CLOCK_50 cycles per LED tick, half a second
	localparam int TICK_DIV_DEFAULT = 25_000_000;

endpackage

/* logic/led_cmd_if.sv */
interface led_cmd_if;
	import cmd_pkg::*;

	// One-cycle pulse, one word handed over
	logic      valid;
	// Captured command word
	cmd_word_u word;
	// Controller still holds a set or invert request
	logic      busy;

	// FIFO side
	modport reader (
		output valid,
		output word,
		input  busy
	);

	// Control side
	modport ctrl (
		input  valid,
		input  word,
		output busy
	);

endinterface

/* logic/fifo_reader.sv */
module fifo_reader (
	input  logic                      CLOCK_50,
	input  logic                      rst_n,
	input  logic [cmd_pkg::CMD_W-1:0] fifo_readdata,
	input  logic                      fifo_empty,
	output logic                      fifo_read,
	led_cmd_if.reader                 cmd
);

	// Four-state read pacing
	typedef enum logic [1:0] {
		S_AWAIT,
		S_DELAY_READ,
		S_READ,
		S_DELAY_AWAIT
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_next;

	// ====================
	// Next state
	// ====================
	always_comb
	begin
		state_next = state;
		case (state)
			S_AWAIT:
			begin
				// Word waiting and the last command taken
				if (!fifo_empty && !cmd.busy)
					state_next = S_DELAY_READ;
			end
			// Pop strobe goes out here
			S_DELAY_READ:  state_next = S_READ;
			// Word valid on the bus now
			S_READ:        state_next = S_DELAY_AWAIT;
			S_DELAY_AWAIT: state_next = S_AWAIT;
			default:       state_next = S_AWAIT;
		endcase
	end

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
			state <= S_AWAIT;
		else
			state <= state_next;
	end

	// Capture at the end of the read cycle
	always_ff @(posedge CLOCK_50)
	begin
		if (state == S_READ)
			cmd.word.raw <= fifo_readdata;
	end

	// One-cycle pop strobe
	assign fifo_read = (state == S_DELAY_READ);

	// Hand-over pulse, word already registered
	assign cmd.valid = (state == S_DELAY_AWAIT);

endmodule

/* logic/led_controller.sv */
module led_controller (
	input  logic                                CLOCK_50,
	input  logic                                rst_n,
	led_cmd_if.ctrl                             cmd,
	input  logic                                applied,
	output logic                                set_req,
	output logic [$clog2(board_pkg::LED_N)-1:0] set_index,
	output logic                                set_level,
	output logic                                run_en,
	output logic                                invert_req,
	output logic [board_pkg::CNT_W-1:0]         cmd_count
);
	import cmd_pkg::*;
	import board_pkg::*;

	cmd_fields_t                 fields;
	logic [$clog2(LED_N)-1:0]    led_num;
	logic                        is_set;

	// ====================
	// Decode
	// ====================
	assign fields = cmd.word.f;

	// LED number from the low bits of x
	assign led_num = fields.x_value[$clog2(LED_N)-1:0];

	// Out-of-range LED makes the set a NOP
	assign is_set = (fields.opcode == OPC_LED_SET) && (led_num < LED_N);

	// ====================
	// Mode and requests
	// ====================
	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			set_req    <= 1'b0;
			invert_req <= 1'b0;
			run_en     <= 1'b0;
			cmd_count  <= '0;
		end
		else
		begin
			// Sequencer took the pending request on its tick
			if (applied)
			begin
				set_req    <= 1'b0;
				invert_req <= 1'b0;
			end
			if (cmd.valid)
			begin
				// Every accepted word counts, wraps at 16 bits
				cmd_count <= cmd_count + 1'b1;
				case (fields.opcode)
					OPC_NOP: ;
					OPC_LED_SET:
					begin
						if (is_set)
							set_req <= 1'b1;
					end
					OPC_RUN_START: run_en     <= 1'b1;
					OPC_RUN_STOP:  run_en     <= 1'b0;
					OPC_INVERT:    invert_req <= 1'b1;
					// Unknown opcodes behave as NOP
					default: ;
				endcase
			end
		end
	end

	// Set arguments, only read while set_req is high
	always_ff @(posedge CLOCK_50)
	begin
		if (cmd.valid && is_set)
		begin
			set_index <= led_num;
			set_level <= fields.y_value[0];
		end
	end

	// Holds off the reader until the tick has acted
	assign cmd.busy = set_req | invert_req;

endmodule

/* logic/led_sequencer.sv */
module led_sequencer #(
	// At least 2, so applied clears a request before the next tick
	parameter int unsigned TICK_DIV = board_pkg::TICK_DIV_DEFAULT
) (
	input  logic                                CLOCK_50,
	input  logic                                rst_n,
	input  logic                                set_req,
	input  logic [$clog2(board_pkg::LED_N)-1:0] set_index,
	input  logic                                set_level,
	input  logic                                run_en,
	input  logic                                invert_req,
	output logic                                applied,
	output logic [board_pkg::LED_N-1:0]         LEDR
);
	import board_pkg::*;

	logic [$clog2(TICK_DIV)-1:0] div_cnt;
	logic                        tick;
	// Binary run pattern, wraps at 1024
	logic [LED_N-1:0]            run_cnt;

	// ====================
	// Tick divider
	// ====================

	// One-cycle enable on the last count
	assign tick = (div_cnt == ($clog2(TICK_DIV))'(TICK_DIV - 1));

	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
			div_cnt <= '0;
		else if (tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// ====================
	// LED update
	// ====================

	// Priority on a tick is set, then run, then invert
	always_ff @(posedge CLOCK_50 or negedge rst_n)
	begin
		if (!rst_n)
		begin
			LEDR    <= '0;
			run_cnt <= '0;
			applied <= 1'b0;
		end
		else
		begin
			// Acknowledge is a single pulse
			applied <= 1'b0;
			if (tick)
			begin
				if (set_req)
				begin
					// Index already range-checked upstream
					LEDR[set_index] <= set_level;
					applied         <= 1'b1;
				end
				else if (run_en)
				begin
					LEDR    <= run_cnt;
					run_cnt <= run_cnt + 1'b1;
				end
				else if (invert_req)
				begin
					// Waits here while the run mode is on
					LEDR    <= ~LEDR;
					applied <= 1'b1;
				end
			end
		end
	end

endmodule

/* logic/hex_display.sv */
module hex_display (
	input  logic [board_pkg::CNT_W-1:0] cmd_count,
	output logic [board_pkg::SEG_W-1:0] HEX0,
	output logic [board_pkg::SEG_W-1:0] HEX1,
	output logic [board_pkg::SEG_W-1:0] HEX2,
	output logic [board_pkg::SEG_W-1:0] HEX3
);
	import board_pkg::*;

	logic [SEG_W-1:0] digit_seg [HEX_DIGITS];

	// Hex nibble to segments, bit 6 is g, bit 0 is a, low lights
	function automatic logic [SEG_W-1:0] seg7(input logic [3:0] nib);
		case (nib)
			4'h0:    seg7 = 7'b1000000;
			4'h1:    seg7 = 7'b1111001;
			4'h2:    seg7 = 7'b0100100;
			4'h3:    seg7 = 7'b0110000;
			4'h4:    seg7 = 7'b0011001;
			4'h5:    seg7 = 7'b0010010;
			4'h6:    seg7 = 7'b0000010;
			4'h7:    seg7 = 7'b1111000;
			4'h8:    seg7 = 7'b0000000;
			4'h9:    seg7 = 7'b0010000;
			4'ha:    seg7 = 7'b0001000;
			// Lower-case b and d tell them apart from 8 and 0
			4'hb:    seg7 = 7'b0000011;
			4'hc:    seg7 = 7'b1000110;
			4'hd:    seg7 = 7'b0100001;
			4'he:    seg7 = 7'b0000110;
			default: seg7 = 7'b0001110;
		endcase
	endfunction

	// ====================
	// One nibble per digit
	// ====================
	always_comb
	begin
		for (int i = 0; i < HEX_DIGITS; i++)
			digit_seg[i] = seg7(cmd_count[i*4 +: 4]);
	end

	// HEX0 is the lowest nibble
	assign HEX0 = digit_seg[0];
	assign HEX1 = digit_seg[1];
	assign HEX2 = digit_seg[2];
	assign HEX3 = digit_seg[3];

endmodule

/* logic/hps_led_ctrl.sv */
module hps_led_ctrl #(
	parameter int unsigned TICK_DIV = board_pkg::TICK_DIV_DEFAULT
) (
	input  logic                        CLOCK_50,
	input  logic                        rst_n,
	// HPS-to-FPGA FIFO
	input  logic [cmd_pkg::CMD_W-1:0]   fifo_readdata,
	input  logic                        fifo_empty,
	output logic                        fifo_read,
	// Board outputs
	output logic [board_pkg::LED_N-1:0] LEDR,
	output logic [board_pkg::SEG_W-1:0] HEX0,
	output logic [board_pkg::SEG_W-1:0] HEX1,
	output logic [board_pkg::SEG_W-1:0] HEX2,
	output logic [board_pkg::SEG_W-1:0] HEX3
);
	import board_pkg::*;

	// Controller to sequencer
	logic                     set_req;
	logic [$clog2(LED_N)-1:0] set_index;
	logic                     set_level;
	logic                     run_en;
	logic                     invert_req;
	// Sequencer acknowledge
	logic                     applied;
	// Shown on HEX3 to HEX0
	logic [CNT_W-1:0]         cmd_count;

	// Reader to controller
	led_cmd_if cmd_bus ();

	// ====================
	// Command path
	// ====================
	fifo_reader u_reader (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.fifo_readdata (fifo_readdata),
		.fifo_empty    (fifo_empty),
		.fifo_read     (fifo_read),
		.cmd           (cmd_bus.reader)
	);

	led_controller u_ctrl (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.cmd        (cmd_bus.ctrl),
		.applied    (applied),
		.set_req    (set_req),
		.set_index  (set_index),
		.set_level  (set_level),
		.run_en     (run_en),
		.invert_req (invert_req),
		.cmd_count  (cmd_count)
	);

	// ====================
	// Outputs
	// ====================
	led_sequencer #(
		.TICK_DIV (TICK_DIV)
	) u_seq (
		.CLOCK_50   (CLOCK_50),
		.rst_n      (rst_n),
		.set_req    (set_req),
		.set_index  (set_index),
		.set_level  (set_level),
		.run_en     (run_en),
		.invert_req (invert_req),
		.applied    (applied),
		.LEDR       (LEDR)
	);

	hex_display u_hex (
		.cmd_count (cmd_count),
		.HEX0      (HEX0),
		.HEX1      (HEX1),
		.HEX2      (HEX2),
		.HEX3      (HEX3)
	);

endmodule

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ====================
// Command words
// ====================

// Fields packed LSB first, opcode then x then y
function automatic logic [CMD_W-1:0] make_word(input logic [OPC_W-1:0] opc,
	input logic [ARG_W-1:0] x, input logic [ARG_W-1:0] y);
	return {y, x, opc};
endfunction

// LED state after one command has reached its tick
function automatic logic [LED_N-1:0] model_leds(input logic [LED_N-1:0] leds,
	input logic [CMD_W-1:0] word);
	logic [3:0]       idx;
	logic [LED_N-1:0] leds_next;
	// LED number in the low bits of x, level in y bit 0
	idx       = word[7:4];
	leds_next = leds;
	if ((word[3:0] == OPC_LED_SET) && (idx < LED_N))
		leds_next[idx] = word[18];
	else if (word[3:0] == OPC_INVERT)
		leds_next = ~leds;
	return leds_next;
endfunction

// Run count, ten bits wide
function automatic logic [LED_N-1:0] model_run(input logic [LED_N-1:0] cnt);
	return cnt + 1'b1;
endfunction

// ====================
// Seven segments
// ====================

// Lit segments as g..a, then inverted for the active-low pins
function automatic logic [SEG_W-1:0] seg_pattern(input logic [3:0] nib);
	logic [SEG_W-1:0] lit;
	case (nib)
		4'h0: lit = 7'b0111111;
		4'h1: lit = 7'b0000110;
		4'h2: lit = 7'b1011011;
		4'h3: lit = 7'b1001111;
		4'h4: lit = 7'b1100110;
		4'h5: lit = 7'b1101101;
		4'h6: lit = 7'b1111101;
		4'h7: lit = 7'b0000111;
		4'h8: lit = 7'b1111111;
		4'h9: lit = 7'b1101111;
		4'ha: lit = 7'b1110111;
		4'hb: lit = 7'b1111100;
		4'hc: lit = 7'b0111001;
		4'hd: lit = 7'b1011110;
		4'he: lit = 7'b1111001;
		default: lit = 7'b1110001;
	endcase
	return ~lit;
endfunction

// HEX3 down to HEX0 for one count value
function automatic logic [4*SEG_W-1:0] hex_expect(input logic [CNT_W-1:0] count);
	return {seg_pattern(count[15:12]), seg_pattern(count[11:8]),
		seg_pattern(count[7:4]), seg_pattern(count[3:0])};
endfunction

`endif

/* testbench/tb_hps_led_ctrl.sv */
module tb_hps_led_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	import cmd_pkg::*;
	import board_pkg::*;

	`include "tb_ref_model.svh"

	// Short tick so the LED modes run quickly
	localparam int TB_TICK = 8;
	localparam int N_SET   = 12;
	// Enough run steps to pass the 10-bit wrap
	localparam int N_RUN   = 1030;

	logic                 CLOCK_50;
	logic                 rst_n;
	logic [CMD_W-1:0]     fifo_readdata;
	logic                 fifo_empty;
	logic                 fifo_read;
	logic [LED_N-1:0]     LEDR;
	logic [SEG_W-1:0]     HEX0;
	logic [SEG_W-1:0]     HEX1;
	logic [SEG_W-1:0]     HEX2;
	logic [SEG_W-1:0]     HEX3;

	// HPS-to-FPGA FIFO model
	logic [CMD_W-1:0]     fifo_q [$];
	// Popped word, goes on the bus one cycle after the strobe
	logic [CMD_W-1:0]     word_next = '0;
	logic                 word_pending = 1'b0;
	integer               seed = 98;
	int                   errors = 0;
	int                   checks = 0;
	int                   tests = 0;
	int                   pushes = 0;
	int                   pops = 0;
	int                   pulses = 0;
	logic [LED_N-1:0]     leds_model = '0;

	// Strobe checker state
	int                   cyc = 0;
	int                   last_read = -100;
	logic                 read_prev = 1'b0;
	logic                 empty_prev = 1'b1;

	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#4 CLOCK_50 = ~CLOCK_50;
	end

	hps_led_ctrl #(
		.TICK_DIV (TB_TICK)
	) UUT (
		.CLOCK_50      (CLOCK_50),
		.rst_n         (rst_n),
		.fifo_readdata (fifo_readdata),
		.fifo_empty    (fifo_empty),
		.fifo_read     (fifo_read),
		.LEDR          (LEDR),
		.HEX0          (HEX0),
		.HEX1          (HEX1),
		.HEX2          (HEX2),
		.HEX3          (HEX3)
	);

	// ====================
	// Helpers
	// ====================

	// One clock, inputs change 1 ns after the edge
	task automatic step();
		@(posedge CLOCK_50);
		#1;
		// Word popped on the last strobe is on the bus for this cycle
		if (word_pending)
		begin
			fifo_readdata = word_next;
			word_pending  = 1'b0;
		end
		// Pop on the strobe
		if (fifo_read && (fifo_q.size() > 0))
		begin
			word_next    = fifo_q.pop_front();
			word_pending = 1'b1;
			pops++;
		end
		fifo_empty = (fifo_q.size() == 0);
	endtask

	task automatic push_word(input logic [CMD_W-1:0] w);
		fifo_q.push_back(w);
		fifo_empty = 1'b0;
		pushes++;
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int base);
		tests++;
		$display("Test %-14s %s", name, (errors == base) ? "ok" : "failed");
	endtask

	task automatic wait_drained(input int limit);
		int n = 0;
		while ((fifo_q.size() != 0) && (n < limit))
		begin
			step();
			n++;
		end
		if (fifo_q.size() != 0)
			report_failure("the design did not read all FIFO words in time");
	endtask

	// Until LEDR equals, or differs from, the given value
	task automatic wait_leds(input logic [LED_N-1:0] value, input bit until_equal,
		input int limit);
		int n = 0;
		while (((LEDR === value) != until_equal) && (n < limit))
		begin
			step();
			n++;
		end
		if ((LEDR === value) != until_equal)
		begin
			if (until_equal)
				report_failure("LEDR did not reach the expected value in time");
			else
				report_failure("LEDR did not change in time");
		end
	endtask

	task automatic wait_hex(input logic [4*SEG_W-1:0] value, input int limit);
		int n = 0;
		while (({HEX3, HEX2, HEX1, HEX0} !== value) && (n < limit))
		begin
			step();
			n++;
		end
		if ({HEX3, HEX2, HEX1, HEX0} !== value)
			report_failure("the hex digits did not show the command count in time");
	endtask

	// LEDR must keep one value for a while
	task automatic hold_leds(input logic [LED_N-1:0] value, input int cycles,
		input string what);
		logic [LED_N-1:0] seen;
		seen = value;
		for (int n = 0; n < cycles; n++)
		begin
			step();
			if (LEDR !== value)
				seen = LEDR;
		end
		check_value(seen, value, what);
	endtask

	// ====================
	// FIFO strobe rules
	// ====================

	// Mid-cycle sampling, prev values are what the DUT saw at the edge
	always @(negedge CLOCK_50)
	begin
		if (rst_n && fifo_read)
		begin
			pulses++;
			checks++;
			assert (!read_prev && !empty_prev && ((cyc - last_read) >= 4))
			else
			begin
				errors++;
				$display("Error at %0t ns: fifo_read pulse broke the FIFO rules", $time);
				$display("  gap %0d cycles, FIFO empty %0b, previous cycle high %0b",
					cyc - last_read, empty_prev, read_prev);
			end
			last_read = cyc;
		end
		read_prev  = fifo_read;
		empty_prev = fifo_empty;
		cyc++;
	end

	// ====================
	// Stimulus and checks
	// ====================
	initial
	begin
		logic [31:0]      r;
		logic [LED_N-1:0] prev;
		logic [LED_N-1:0] run_exp;
		int               base;
		int               n_misc;

		rst_n         = 1'b0;
		fifo_readdata = '0;
		fifo_empty    = 1'b1;
		repeat (2) @(posedge CLOCK_50);
		#1;
		rst_n = 1'b1;

		// Reset state, nothing read from an empty FIFO
		base = errors;
		check_value(LEDR, '0, "LEDR after reset");
		check_value({HEX3, HEX2, HEX1, HEX0}, hex_expect('0), "HEX after reset");
		repeat (3 * TB_TICK) step();
		check_value(pulses, 0, "reads from an empty FIFO");
		report_test("reset", base);

		// Random LED sets, some with an LED number out of range
		base = errors;
		for (int i = 0; i < N_SET; i++)
		begin
			r = $random(seed);
			push_word(make_word(OPC_LED_SET, r[13:0], r[27:14]));
			leds_model = model_leds(leds_model, make_word(OPC_LED_SET, r[13:0], r[27:14]));
			wait_drained(8 * TB_TICK);
			wait_leds(leds_model, 1'b1, 4 * TB_TICK);
			check_value(LEDR, leds_model, "LEDR after LED set");
		end
		hold_leds(leds_model, 3 * TB_TICK, "LEDR after last LED set");
		report_test("led set", base);

		// One inversion, then no further change
		base = errors;
		prev = LEDR;
		push_word(make_word(OPC_INVERT, '0, '0));
		leds_model = model_leds(leds_model, make_word(OPC_INVERT, '0, '0));
		wait_leds(prev, 1'b0, 4 * TB_TICK);
		check_value(LEDR, leds_model, "LEDR after invert");
		hold_leds(leds_model, 5 * TB_TICK, "LEDR ticks after invert");
		report_test("invert", base);

		// Run count starts from zero, a start value of zero shows as no change
		base = errors;
		run_exp = (leds_model == '0) ? 10'd1 : 10'd0;
		push_word(make_word(OPC_RUN_START, '0, '0));
		for (int i = 0; i < N_RUN; i++)
		begin
			prev = LEDR;
			wait_leds(prev, 1'b0, 4 * TB_TICK);
			check_value(LEDR, run_exp, "LEDR in run mode");
			leds_model = run_exp;
			run_exp    = model_run(run_exp);
		end
		// One more tick may still count before the stop lands
		push_word(make_word(OPC_RUN_STOP, '0, '0));
		repeat (3 * TB_TICK)
		begin
			prev = LEDR;
			step();
			if (LEDR !== prev)
			begin
				check_value(LEDR, run_exp, "LEDR while run stops");
				leds_model = run_exp;
				run_exp    = model_run(run_exp);
			end
		end
		wait_drained(TB_TICK);
		hold_leds(leds_model, 5 * TB_TICK, "LEDR after run stop");
		report_test("run count", base);

		// NOPs and unknown opcodes, counted but no LED effect
		base = errors;
		r = $random(seed);
		n_misc = 250 + r[5:0];
		for (int i = 0; i < n_misc; i++)
		begin
			r = $random(seed);
			if ((r[3:0] >= OPC_LED_SET) && (r[3:0] <= OPC_INVERT))
				r[3:0] = OPC_NOP;
			push_word(r);
		end
		wait_drained(6 * n_misc + 16);
		wait_hex(hex_expect(pops[15:0]), TB_TICK);
		check_value({HEX3, HEX2, HEX1, HEX0}, hex_expect(pops[15:0]), "HEX digits");
		check_value(LEDR, leds_model, "LEDR after NOP words");
		report_test("command count", base);

		// Strobe rules are checked all along, here only the totals
		base = errors;
		check_value(pulses, pushes, "fifo_read pulse count");
		check_value(pops, pushes, "words popped");
		report_test("fifo pacing", base);

		$display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* hps_led_ctrl.f */
+incdir+testbench
logic/cmd_pkg.sv
logic/board_pkg.sv
logic/led_cmd_if.sv
logic/fifo_reader.sv
logic/led_controller.sv
logic/led_sequencer.sv
logic/hex_display.sv
logic/hps_led_ctrl.sv
testbench/tb_hps_led_ctrl.sv

/* Bender.yml */
package:
  name: hps_led_ctrl

sources:
  - files:
      - logic/cmd_pkg.sv
      - logic/board_pkg.sv
      - logic/led_cmd_if.sv
      - logic/fifo_reader.sv
      - logic/led_controller.sv
      - logic/led_sequencer.sv
      - logic/hex_display.sv
      - logic/hps_led_ctrl.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_hps_led_ctrl.sv
